//--- hw/huffman_pkg.sv
package huffman_pkg;

	// ========================================================================
	// symbol alphabet and word sizes
	// ========================================================================

	localparam int SYMBOL_COUNT = 6;  // symbols 1 to 6
	localparam int CODE_W = 8;        // code and mask width

	// default count width, the top level may widen it
	localparam int COUNT_W = 8;

	// ========================================================================
	// shared types
	// ========================================================================

	// one symbol count, also the range every input count must fit in
	typedef logic [COUNT_W-1:0] count_t;

	// bit 0 stands for symbol 1
	// a larger set wins a tie on equal counts
	typedef logic [SYMBOL_COUNT-1:0] sym_set_t;

	// right-aligned code or length mask
	typedef logic [CODE_W-1:0] code_t;

endpackage

//--- hw/hist_if.sv
`timescale 1ns/1ps

// finished histogram handed from the decode stage to the merge stage
interface hist_if #(
	parameter int count_width = huffman_pkg::COUNT_W
);
	import huffman_pkg::*;

	logic [SYMBOL_COUNT-1:0][count_width-1:0] counts;  // word 0 holds symbol 1
	logic counts_ready;                                // high from cnt_valid until reset

	modport hist_src (
		output counts,
		output counts_ready
	);

	modport hist_dst (
		input counts,
		input counts_ready
	);

endinterface

//--- hw/merge_if.sv
`timescale 1ns/1ps

// one tree merge per valid cycle, no back-pressure
interface merge_if;
	import huffman_pkg::*;

	logic step_valid;
	sym_set_t low_set;   // smaller node, branch 1
	sym_set_t high_set;  // other node, branch 0
	logic last_step;     // this merge forms the root

	modport step_src (
		output step_valid,
		output low_set,
		output high_set,
		output last_step
	);

	modport step_dst (
		input step_valid,
		input low_set,
		input high_set,
		input last_step
	);

endinterface

//--- hw/symbol_histogram.sv
`timescale 1ns/1ps

module symbol_histogram #(
	parameter int count_width = huffman_pkg::COUNT_W
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       gray_valid,
	input  logic [7:0] gray_data,
	output logic       cnt_valid,
	hist_if.hist_src   hist
);
	import huffman_pkg::*;

	localparam logic [1:0] st_idle      = 2'd0;
	localparam logic [1:0] st_receiving = 2'd1;
	localparam logic [1:0] st_reported  = 2'd2;

	logic [1:0] state;
	logic [SYMBOL_COUNT-1:0] hit;  // one-hot symbol decode

	// values outside 1..6 hit nothing
	always_comb begin
		for (int s = 0; s < SYMBOL_COUNT; s++) begin
			hit[s] = gray_valid && (state != st_reported) && (gray_data == 8'(s + 1));
		end
	end

	// ========================================================================
	// receive FSM, one burst per reset
	// ========================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= st_idle;
			cnt_valid <= 1'b0;
		end else begin
			cnt_valid <= 1'b0;
			case (state)
				st_idle: begin
					if (gray_valid)
						state <= st_receiving;
				end
				st_receiving: begin
					if (!gray_valid) begin  // first idle cycle ends the burst
						state     <= st_reported;
						cnt_valid <= 1'b1;
					end
				end
				default: state <= st_reported;  // stays here until reset
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			hist.counts <= '0;
		end else begin
			for (int s = 0; s < SYMBOL_COUNT; s++) begin
				if (hit[s])
					hist.counts[s] <= hist.counts[s] + count_width'(1);
			end
		end
	end

	assign hist.counts_ready = (state == st_reported);

	a_cnt_valid_single: assert property (@(posedge clk) disable iff (reset)
		cnt_valid |=> !cnt_valid);

endmodule

//--- hw/huffman_merge.sv
`timescale 1ns/1ps

module huffman_merge #(
	parameter int count_width = huffman_pkg::COUNT_W
) (
	input logic       clk,
	input logic       reset,
	hist_if.hist_dst  hist,
	merge_if.step_src step
);
	import huffman_pkg::*;

	localparam int node_w = count_width + 3;  // six summed counts never overflow
	localparam int idx_w  = $clog2(SYMBOL_COUNT);

	// node list, one slot per symbol
	logic [node_w-1:0] node_cnt [SYMBOL_COUNT];
	sym_set_t node_set [SYMBOL_COUNT];
	logic [SYMBOL_COUNT-1:0] node_live;

	logic loaded;
	logic load;
	logic [idx_w:0] live_total;
	logic [idx_w-1:0] lo_idx;
	logic [idx_w-1:0] hi_idx;
	logic [SYMBOL_COUNT-1:0] count_nz;
	logic [SYMBOL_COUNT-1:0] count_fit;

	// lower count first, on a tie the larger set counts as smaller
	function automatic logic node_less(
		input logic [node_w-1:0] cnt_a,
		input sym_set_t set_a,
		input logic [node_w-1:0] cnt_b,
		input sym_set_t set_b
	);
		return (cnt_a < cnt_b) || ((cnt_a == cnt_b) && (set_a > set_b));
	endfunction

	assign load = hist.counts_ready && !loaded;
	assign live_total = (idx_w + 1)'($countones(node_live));

	always_comb begin
		for (int i = 0; i < SYMBOL_COUNT; i++) begin
			count_nz[i]  = |hist.counts[i];
			count_fit[i] = (hist.counts[i] >> $bits(count_t)) == '0;
		end
	end

	// ========================================================================
	// two-minimum search over the live nodes
	// ========================================================================

	always_comb begin
		logic lo_found;
		logic hi_found;
		lo_found = 1'b0;
		hi_found = 1'b0;
		lo_idx   = '0;
		hi_idx   = '0;
		for (int i = 0; i < SYMBOL_COUNT; i++) begin
			if (node_live[i] && (!lo_found ||
				node_less(node_cnt[i], node_set[i], node_cnt[lo_idx], node_set[lo_idx]))) begin
				lo_idx   = idx_w'(i);
				lo_found = 1'b1;
			end
		end
		// runner-up, skipping the winner
		for (int i = 0; i < SYMBOL_COUNT; i++) begin
			if (node_live[i] && (idx_w'(i) != lo_idx) && (!hi_found ||
				node_less(node_cnt[i], node_set[i], node_cnt[hi_idx], node_set[hi_idx]))) begin
				hi_idx   = idx_w'(i);
				hi_found = 1'b1;
			end
		end
	end

	assign step.step_valid = loaded && (live_total >= (idx_w + 1)'(2));
	assign step.low_set    = node_set[lo_idx];
	assign step.high_set   = node_set[hi_idx];
	assign step.last_step  = step.step_valid && (live_total == (idx_w + 1)'(2));

	// ========================================================================
	// node list update
	// ========================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			loaded    <= 1'b0;
			node_live <= '0;
		end else if (load) begin
			loaded    <= 1'b1;
			node_live <= count_nz;  // absent symbols stay out of the tree
		end else if (step.step_valid) begin
			node_live[hi_idx] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			for (int i = 0; i < SYMBOL_COUNT; i++) begin
				node_cnt[i] <= node_w'(hist.counts[i]);
				node_set[i] <= sym_set_t'(1 << i);
			end
		end else if (step.step_valid) begin
			node_cnt[lo_idx] <= node_cnt[lo_idx] + node_cnt[hi_idx];  // merged node
			node_set[lo_idx] <= node_set[lo_idx] | node_set[hi_idx];
		end
	end

	// histogram must leave a real tree and counts below 256
	a_load_counts: assert property (@(posedge clk) disable iff (reset)
		load |-> ($countones(count_nz) >= 2) && (&count_fit));

endmodule

//--- hw/code_builder.sv
`timescale 1ns/1ps

module code_builder (
	input  logic clk,
	input  logic reset,
	output logic code_valid,
	output huffman_pkg::code_t [huffman_pkg::SYMBOL_COUNT-1:0] codes,
	output huffman_pkg::code_t [huffman_pkg::SYMBOL_COUNT-1:0] masks,
	merge_if.step_dst step
);
	import huffman_pkg::*;

	logic aligning;
	logic [SYMBOL_COUNT-1:0] aligned;
	logic [SYMBOL_COUNT-1:0] mask_ok;

	// unused symbols keep a zero mask and count as aligned
	always_comb begin
		for (int s = 0; s < SYMBOL_COUNT; s++) begin
			aligned[s] = (masks[s] == '0) || masks[s][0];
			mask_ok[s] = (masks[s] & (masks[s] + code_t'(1))) == '0;  // ones from bit 0 up
		end
	end

	// ========================================================================
	// branch bits enter at the top, root branch arrives last
	// ========================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			codes      <= '0;
			masks      <= '0;
			aligning   <= 1'b0;
			code_valid <= 1'b0;
		end else if (step.step_valid) begin
			for (int s = 0; s < SYMBOL_COUNT; s++) begin
				if (step.low_set[s]) begin
					codes[s] <= {1'b1, codes[s][CODE_W-1:1]};
					masks[s] <= {1'b1, masks[s][CODE_W-1:1]};
				end else if (step.high_set[s]) begin
					codes[s] <= {1'b0, codes[s][CODE_W-1:1]};
					masks[s] <= {1'b1, masks[s][CODE_W-1:1]};
				end
			end
			if (step.last_step)
				aligning <= 1'b1;
		end else if (aligning) begin
			if (&aligned) begin
				aligning   <= 1'b0;
				code_valid <= 1'b1;  // held until reset
			end else begin
				// slide down until the mask reaches bit 0
				for (int s = 0; s < SYMBOL_COUNT; s++) begin
					if (!aligned[s]) begin
						codes[s] <= codes[s] >> 1;
						masks[s] <= masks[s] >> 1;
					end
				end
			end
		end
	end

	a_masks_contiguous: assert property (@(posedge clk) disable iff (reset)
		code_valid |-> &mask_ok);

endmodule

//--- hw/huffman_top.sv
`timescale 1ns/1ps

module huffman_top #(
	parameter int count_width = huffman_pkg::COUNT_W
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   gray_valid,
	input  logic [7:0]             gray_data,
	output logic                   cnt_valid,
	output logic [count_width-1:0] cnt1,
	output logic [count_width-1:0] cnt2,
	output logic [count_width-1:0] cnt3,
	output logic [count_width-1:0] cnt4,
	output logic [count_width-1:0] cnt5,
	output logic [count_width-1:0] cnt6,
	output logic                   code_valid,
	output huffman_pkg::code_t     hc1,
	output huffman_pkg::code_t     hc2,
	output huffman_pkg::code_t     hc3,
	output huffman_pkg::code_t     hc4,
	output huffman_pkg::code_t     hc5,
	output huffman_pkg::code_t     hc6,
	output huffman_pkg::code_t     m1,
	output huffman_pkg::code_t     m2,
	output huffman_pkg::code_t     m3,
	output huffman_pkg::code_t     m4,
	output huffman_pkg::code_t     m5,
	output huffman_pkg::code_t     m6
);
	import huffman_pkg::*;

	code_t [SYMBOL_COUNT-1:0] codes;
	code_t [SYMBOL_COUNT-1:0] masks;

	hist_if #(.count_width(count_width)) hist ();
	merge_if step ();

	// ========================================================================
	// histogram -> merge -> code builder
	// ========================================================================

	symbol_histogram #(
		.count_width(count_width)
	) i_symbol_histogram (
		.clk       (clk),
		.reset     (reset),
		.gray_valid(gray_valid),
		.gray_data (gray_data),
		.cnt_valid (cnt_valid),
		.hist      (hist.hist_src)
	);

	huffman_merge #(
		.count_width(count_width)
	) i_huffman_merge (
		.clk  (clk),
		.reset(reset),
		.hist (hist.hist_dst),
		.step (step.step_src)
	);

	code_builder i_code_builder (
		.clk       (clk),
		.reset     (reset),
		.code_valid(code_valid),
		.codes     (codes),
		.masks     (masks),
		.step      (step.step_dst)
	);

	// array word 0 is symbol 1
	assign cnt1 = hist.counts[0];
	assign cnt2 = hist.counts[1];
	assign cnt3 = hist.counts[2];
	assign cnt4 = hist.counts[3];
	assign cnt5 = hist.counts[4];
	assign cnt6 = hist.counts[5];

	assign hc1 = codes[0];
	assign hc2 = codes[1];
	assign hc3 = codes[2];
	assign hc4 = codes[3];
	assign hc5 = codes[4];
	assign hc6 = codes[5];

	assign m1 = masks[0];
	assign m2 = masks[1];
	assign m3 = masks[2];
	assign m4 = masks[3];
	assign m5 = masks[4];
	assign m6 = masks[5];

endmodule

//--- verification/tb_huffman.sv
`timescale 1ns/1ps

module tb_huffman;

	localparam int cw = 8;
	localparam int max_burst = 64;
	localparam int code_timeout = 64;  // cycles from cnt_valid to code_valid

	logic clk;
	logic reset;
	logic gray_valid;
	logic [7:0] gray_data;
	logic cnt_valid;
	logic code_valid;
	logic [cw-1:0] cnt1;
	logic [cw-1:0] cnt2;
	logic [cw-1:0] cnt3;
	logic [cw-1:0] cnt4;
	logic [cw-1:0] cnt5;
	logic [cw-1:0] cnt6;
	logic [7:0] hc1;
	logic [7:0] hc2;
	logic [7:0] hc3;
	logic [7:0] hc4;
	logic [7:0] hc5;
	logic [7:0] hc6;
	logic [7:0] m1;
	logic [7:0] m2;
	logic [7:0] m3;
	logic [7:0] m4;
	logic [7:0] m5;
	logic [7:0] m6;

	int fd;
	int rc;
	int errors;
	int checks;
	int records;
	int burst_len;
	logic [31:0] seed;
	logic [8*16-1:0] test_name;
	logic [8*128-1:0] line;
	logic [7:0] burst [max_burst];
	logic [7:0] exp_cnt [6];
	logic [7:0] exp_code [6];
	logic [7:0] exp_mask [6];

	huffman_top #(
		.count_width(cw)
	) i_huffman_top (
		.clk       (clk),
		.reset     (reset),
		.gray_valid(gray_valid),
		.gray_data (gray_data),
		.cnt_valid (cnt_valid),
		.cnt1(cnt1), .cnt2(cnt2), .cnt3(cnt3), .cnt4(cnt4), .cnt5(cnt5), .cnt6(cnt6),
		.code_valid(code_valid),
		.hc1(hc1), .hc2(hc2), .hc3(hc3), .hc4(hc4), .hc5(hc5), .hc6(hc6),
		.m1(m1), .m2(m2), .m3(m3), .m4(m4), .m5(m5), .m6(m6)
	);

	always #50 clk = ~clk;

	task automatic check_value(input string label, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error %0s %0s: expected %0h, actual %0h",
				test_name, label, expected, actual);
		end
	endtask

	// zero selects the post-reset values instead of the golden ones
	task automatic check_counts(input logic zero);
		logic [cw-1:0] act [6];
		act = '{cnt1, cnt2, cnt3, cnt4, cnt5, cnt6};
		for (int s = 0; s < 6; s++)
			check_value($sformatf("cnt%0d", s + 1), zero ? 32'd0 : exp_cnt[s], act[s]);
	endtask

	task automatic check_codes(input logic zero);
		logic [7:0] act_code [6];
		logic [7:0] act_mask [6];
		act_code = '{hc1, hc2, hc3, hc4, hc5, hc6};
		act_mask = '{m1, m2, m3, m4, m5, m6};
		for (int s = 0; s < 6; s++) begin
			check_value($sformatf("hc%0d", s + 1), zero ? 32'd0 : exp_code[s], act_code[s]);
			check_value($sformatf("m%0d", s + 1), zero ? 32'd0 : exp_mask[s], act_mask[s]);
		end
	endtask

	task automatic apply_reset;
		@(posedge clk);
		#1;
		reset = 1'b1;
		gray_valid = 1'b0;
		gray_data = 8'h00;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	task automatic drive_burst;
		logic [7:0] value;
		logic [31:0] rnd;
		for (int i = 0; i < burst_len; i++) begin
			value = burst[i];
			if (value == 8'h00) begin
				rnd = $random(seed);
				value = rnd[7:0];
				if (value >= 8'd1 && value <= 8'd6)
					value = value + 8'h10;  // push it out of the symbol range
			end
			@(posedge clk);
			#1;
			gray_valid = 1'b1;
			gray_data = value;
		end
		@(posedge clk);
		#1;
		gray_valid = 1'b0;
		gray_data = 8'h00;
	endtask

	// ========================================================================
	// golden record reader
	// ========================================================================

	task automatic read_expected;
		logic [31:0] word;
		int got;
		got = $fscanf(fd, "%d", burst_len);
		if (burst_len > max_burst)
			burst_len = max_burst;
		for (int i = 0; i < burst_len; i++) begin
			got += $fscanf(fd, "%h", word);
			burst[i] = word[7:0];
		end
		for (int s = 0; s < 18; s++) begin
			got += $fscanf(fd, "%h", word);
			if (s < 6)
				exp_cnt[s] = word[7:0];
			else if (s < 12)
				exp_code[s - 6] = word[7:0];
			else
				exp_mask[s - 12] = word[7:0];
		end
		if (got != burst_len + 19) begin
			$display("golden record %0s is incomplete", test_name);
			errors++;
		end
	endtask

	task automatic run_record;
		int cycles;
		apply_reset;
		@(negedge clk);
		check_value("cnt_valid after reset", 0, cnt_valid);
		check_value("code_valid after reset", 0, code_valid);
		check_counts(1'b1);
		check_codes(1'b1);
		drive_burst;
		cycles = 0;
		while (!cnt_valid && cycles < 8) begin
			@(negedge clk);
			cycles++;
		end
		if (!cnt_valid) begin
			$display("cnt_valid never rose after the burst in %0s", test_name);
			errors++;
			return;
		end
		check_value("cnt_valid latency", 2, cycles);  // one idle cycle before the pulse
		check_counts(1'b0);
		@(negedge clk);
		check_value("cnt_valid width", 0, cnt_valid);
		cycles = 0;
		while (!code_valid && cycles < code_timeout) begin
			@(negedge clk);
			cycles++;
		end
		if (!code_valid) begin
			$display("code_valid never rose in %0s", test_name);
			errors++;
			return;
		end
		check_codes(1'b0);
		repeat (20) begin
			@(negedge clk);
			check_value("code_valid hold", 1, code_valid);
		end
	endtask

	// ========================================================================
	// main sequence
	// ========================================================================

	initial begin
		logic done;
		clk = 1'b0;
		reset = 1'b1;
		gray_valid = 1'b0;
		gray_data = 8'h00;
		seed = 32'h3ad52f25;
		errors = 0;
		checks = 0;
		records = 0;
		done = 1'b0;
		test_name = "none";
		fd = $fopen("verification/huffman_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open verification/huffman_golden.txt");
			errors++;
			done = 1'b1;
		end
		while (!done) begin
			rc = $fscanf(fd, "%s", test_name);
			if (rc != 1) begin
				done = 1'b1;
			end else if (test_name == "#") begin
				rc = $fgets(line, fd);  // rest of a comment line
			end else begin
				read_expected;
				run_record;
				records++;
			end
		end
		if (fd != 0)
			$fclose(fd);
		if (fd != 0 && records == 0) begin
			$display("the golden file holds no test records");
			errors++;
		end
		$display("records %0d, checks %0d, errors %0d", records, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- compile.f
hw/huffman_pkg.sv
hw/hist_if.sv
hw/merge_if.sv
hw/symbol_histogram.sv
hw/huffman_merge.sv
hw/code_builder.sv
hw/huffman_top.sv
verification/tb_huffman.sv

//--- Bender.yml
package:
  name: huffman_encoder

sources:
  - hw/huffman_pkg.sv
  - hw/hist_if.sv
  - hw/merge_if.sv
  - hw/symbol_histogram.sv
  - hw/huffman_merge.sv
  - hw/code_builder.sv
  - hw/huffman_top.sv
  - target: test
    files:
      - verification/tb_huffman.sv

//--- verification/huffman_golden.txt
# record line one holds the test name and the burst length in decimal
# line two holds the burst symbols in hex, 00 marks a random out-of-range filler
# line three holds cnt1..cnt6, hc1..hc6 and m1..m6, all hex
basic 21
04 06 01 05 04 03 06 02 04 05 06 01 04 03 05 06 04 01 05 06 04
03 01 02 06 04 05  00 03 02 01 03 02  07 0f 0f 03 03 03
filler 17
02 07 01 00 05 02 ff 03 00 06 04 3c 02 00 01 05 80
02 03 01 01 02 01  02 00 03 04 03 05  03 03 07 0f 03 0f
ties 13
01 02 03 00 04 05 06 06 05 04 03 02 01
02 02 02 02 02 02  02 03 00 01 02 03  03 03 07 07 07 07
absent 7
02 04 09 02 00 06 02
00 03 00 01 00 01  00 00 00 02 00 03  00 01 00 03 00 03
pair 5
05 03 00 05 03
00 00 02 00 02 00  00 00 00 00 01 00  00 00 01 00 01 00
